//--- Makefile
TOP := mem_sys_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- sim.f
source/mem_map_pkg.sv
source/mem_req_pkg.sv
source/simple_fifo.sv
source/bc_msg_unpack.sv
source/bank_port_arbiter.sv
source/dmem_bank.sv
source/fast_dmem.sv
source/dma_rd_resp.sv
source/mem_sys.sv
verification/mem_sys_tb.sv

//--- source/bank_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bank_port_arbiter import mem_map_pkg::*, mem_req_pkg::*; #(
  parameter int CMD_FIFO_DEPTH_BITS = 2
) (
  input  wire             clk,
  input  wire             rst,

  input  wire             dma_wr_en,
  input  wire line_wr_t   dma_wr,
  output logic            dma_wr_ready,

  input  wire             dma_rd_en,
  input  wire dmem_addr_t dma_rd_addr,
  output logic            dma_rd_ready,

  input  wire             bc_wr_valid,
  input  wire line_wr_t   bc_wr,

  input  wire             resp_room,

  output bank_port_t      port_a_b0,
  output bank_port_t      port_a_b1,
  output logic            rd_grant,
  output logic            rd_grant_bank
);

  line_wr_t   wr_head;
  logic       wr_head_valid;
  dmem_addr_t rd_head;
  logic       rd_head_valid;
  logic [1:0] bc_hit;
  logic [1:0] wr_hit;
  logic [1:0] wr_gnt;
  logic [1:0] rd_gnt;

  // Builds the port A command of one bank from the winning source
  function automatic bank_port_t port_cmd(input logic bc, input logic wr, input logic rd,
                                          input line_wr_t bcw, input line_wr_t dw,
                                          input dmem_addr_t ra);
    bank_port_t p;
    p = '0;
    if (bc) begin
      p.en      = 1'b1;
      p.wen     = bcw.strb;
      p.addr    = bcw.addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
      p.wr_data = bcw.data;
    end else if (wr) begin
      p.en      = 1'b1;
      p.wen     = dw.strb;
      p.addr    = dw.addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
      p.wr_data = dw.data;
    end else if (rd) begin
      p.en      = 1'b1;
      p.rd      = 1'b1;
      p.addr    = ra[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
    end
    return p;
  endfunction

  ////////////////////////////////////////
  // DMA command queues
  ////////////////////////////////////////

  simple_fifo #(
    .WIDTH     ($bits(line_wr_t)),
    .DEPTH_BITS(CMD_FIFO_DEPTH_BITS)
  ) wr_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (dma_wr_en),
    .din       (dma_wr),
    .din_ready (dma_wr_ready),
    .dout_valid(wr_head_valid),
    .dout      (wr_head),
    .dout_ready(|wr_gnt)
  );

  simple_fifo #(
    .WIDTH     (DMEM_ADDR_WIDTH),
    .DEPTH_BITS(CMD_FIFO_DEPTH_BITS)
  ) rd_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (dma_rd_en),
    .din       (dma_rd_addr),
    .din_ready (dma_rd_ready),
    .dout_valid(rd_head_valid),
    .dout      (rd_head),
    .dout_ready(|rd_gnt)
  );

  ////////////////////////////////////////
  // Per-bank priority
  ////////////////////////////////////////

  // Broadcast first, then the DMA write head, then the DMA read head
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      bc_hit[b] = bc_wr_valid && (bc_wr.addr[LINE_ADDR_BITS] == 1'(b));
      wr_hit[b] = wr_head_valid && (wr_head.addr[LINE_ADDR_BITS] == 1'(b));
      wr_gnt[b] = wr_hit[b] && !bc_hit[b];
      // A read also needs a free slot in the response path
      rd_gnt[b] = rd_head_valid && resp_room && (rd_head[LINE_ADDR_BITS] == 1'(b))
                  && !bc_hit[b] && !wr_hit[b];
    end
  end

  assign port_a_b0 = port_cmd(bc_hit[0], wr_gnt[0], rd_gnt[0], bc_wr, wr_head, rd_head);
  assign port_a_b1 = port_cmd(bc_hit[1], wr_gnt[1], rd_gnt[1], bc_wr, wr_head, rd_head);

  assign rd_grant      = |rd_gnt;
  assign rd_grant_bank = rd_gnt[1];

endmodule

`default_nettype wire

//--- source/bc_msg_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module bc_msg_unpack import mem_map_pkg::*, mem_req_pkg::*; (
  input  wire       clk,
  input  wire       rst,

  input  wire       msg_valid,
  input  wire msg_t msg,

  output logic      bc_wr_valid,
  output line_wr_t  bc_wr
);

  localparam int WORD_BITS  = 32;
  localparam int WORD_BYTES = 4;

  logic [MSG_ADDR_WIDTH-1:0] msg_addr_r;
  logic [WORD_BYTES-1:0]     msg_strb_r;
  logic [WORD_BITS-1:0]      msg_data_r;
  logic                      msg_valid_r;

  // First stage just splits and registers the fields
  always_ff @(posedge clk) begin
    msg_addr_r <= msg[MSG_WIDTH-1 -: MSG_ADDR_WIDTH];
    msg_strb_r <= msg[WORD_BITS +: WORD_BYTES];
    msg_data_r <= msg[WORD_BITS-1:0];
  end

  // Second stage places the word on the line inside the broadcast region
  always_ff @(posedge clk) begin
    bc_wr.addr <= dmem_addr_t'({msg_addr_r, 2'b00}) + dmem_addr_t'(BC_START_ADDR);
    bc_wr.strb <= strb_t'(msg_strb_r) << {msg_addr_r[LINE_ADDR_BITS-3:0], 2'b00};
    bc_wr.data <= data_t'(msg_data_r) << {msg_addr_r[LINE_ADDR_BITS-3:0], 5'b00000};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      msg_valid_r <= 1'b0;
      bc_wr_valid <= 1'b0;
    end else begin
      msg_valid_r <= msg_valid;
      bc_wr_valid <= msg_valid_r;
    end
  end

endmodule

`default_nettype wire

//--- source/dma_rd_resp.sv
`timescale 1ns/1ps
`default_nettype none

module dma_rd_resp import mem_map_pkg::*; #(
  parameter int RESP_FIFO_DEPTH_BITS = 3
) (
  input  wire        clk,
  input  wire        rst,

  input  wire        rd_grant,
  input  wire        rd_grant_bank,
  input  wire data_t rd_data_b0,
  input  wire data_t rd_data_b1,
  output logic       resp_room,

  output logic       dma_rd_resp_valid,
  output data_t      dma_rd_resp_data,
  input  wire        dma_rd_resp_ready
);

  logic                        grant_r;
  logic                        bank_r;
  data_t                       push_data;
  logic                        resp_pop;
  // Reads granted but not yet taken by the DMA, in flight or queued
  logic [RESP_FIFO_DEPTH_BITS:0] in_use;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_r <= 1'b0;
    end else begin
      grant_r <= rd_grant;
    end
  end

  always_ff @(posedge clk) begin
    bank_r <= rd_grant_bank;
  end

  // Bank data is valid the cycle after the grant
  assign push_data = bank_r ? rd_data_b1 : rd_data_b0;
  assign resp_pop  = dma_rd_resp_valid && dma_rd_resp_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_use <= '0;
    end else begin
      case ({rd_grant, resp_pop})
        2'b10:   in_use <= in_use + 1'b1;
        2'b01:   in_use <= in_use - 1'b1;
        default: in_use <= in_use;
      endcase
    end
  end

  // in_use tops out at the FIFO depth, so its top bit means no room
  assign resp_room = !in_use[RESP_FIFO_DEPTH_BITS];

  // Credits keep this FIFO from ever refusing a push
  simple_fifo #(
    .WIDTH     (DATA_WIDTH),
    .DEPTH_BITS(RESP_FIFO_DEPTH_BITS)
  ) resp_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (grant_r),
    .din       (push_data),
    .din_ready (),
    .dout_valid(dma_rd_resp_valid),
    .dout      (dma_rd_resp_data),
    .dout_ready(dma_rd_resp_ready)
  );

endmodule

`default_nettype wire

//--- source/dmem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_bank import mem_map_pkg::*; (
  input  wire             clk,

  input  wire             ena,
  input  wire             rena,
  input  wire strb_t      wena,
  input  wire bank_addr_t addra,
  input  wire data_t      dina,
  output data_t           douta,

  input  wire             enb,
  input  wire             renb,
  input  wire strb_t      wenb,
  input  wire bank_addr_t addrb,
  input  wire data_t      dinb,
  output data_t           doutb
);

  localparam int LINES = 2 ** BANK_ADDR_WIDTH;

  data_t mem [LINES];

  // Both ports in one process, reads return the old contents on a collision
  always_ff @(posedge clk) begin
    if (ena) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wena[i]) begin
          mem[addra][i*8 +: 8] <= dina[i*8 +: 8];
        end
      end
      if (rena) begin
        douta <= mem[addra];
      end
    end
    if (enb) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wenb[i]) begin
          mem[addrb][i*8 +: 8] <= dinb[i*8 +: 8];
        end
      end
      if (renb) begin
        doutb <= mem[addrb];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/fast_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module fast_dmem import mem_map_pkg::*, mem_req_pkg::*; (
  input  wire             clk,
  input  wire             rst,

  input  wire bank_port_t port_a_b0,
  input  wire bank_port_t port_a_b1,
  input  wire core_req_t  core,

  output data_t           rd_data_b0,
  output data_t           rd_data_b1,
  output data_t           core_rd_data,
  output logic            core_rd_valid
);

  logic       core_bank;
  logic       core_en_b0;
  logic       core_en_b1;
  strb_t      core_wen;
  bank_addr_t core_addr;
  data_t      core_data_b0;
  data_t      core_data_b1;
  logic       core_rd_r;
  logic       core_bank_r;

  // Core owns port B, the bank follows the bank-select bit of its address
  assign core_bank  = core.addr[LINE_ADDR_BITS];
  assign core_en_b0 = core.en && !core_bank;
  assign core_en_b1 = core.en && core_bank;
  assign core_wen   = core.wen ? core.strb : '0;
  assign core_addr  = core.addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];

  dmem_bank bank0 (
    .clk  (clk),
    .ena  (port_a_b0.en),
    .rena (port_a_b0.rd),
    .wena (port_a_b0.wen),
    .addra(port_a_b0.addr),
    .dina (port_a_b0.wr_data),
    .douta(rd_data_b0),
    .enb  (core_en_b0),
    .renb (!core.wen),
    .wenb (core_wen),
    .addrb(core_addr),
    .dinb (core.wr_data),
    .doutb(core_data_b0)
  );

  dmem_bank bank1 (
    .clk  (clk),
    .ena  (port_a_b1.en),
    .rena (port_a_b1.rd),
    .wena (port_a_b1.wen),
    .addra(port_a_b1.addr),
    .dina (port_a_b1.wr_data),
    .douta(rd_data_b1),
    .enb  (core_en_b1),
    .renb (!core.wen),
    .wenb (core_wen),
    .addrb(core_addr),
    .dinb (core.wr_data),
    .doutb(core_data_b1)
  );

  // Remember which bank answers the core on the next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      core_rd_r   <= 1'b0;
      core_bank_r <= 1'b0;
    end else begin
      core_rd_r   <= core.en && !core.wen;
      core_bank_r <= core_bank;
    end
  end

  assign core_rd_valid = core_rd_r;
  assign core_rd_data  = core_bank_r ? core_data_b1 : core_data_b0;

endmodule

`default_nettype wire

//--- source/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  ////////////////////////////////////////
  // Line geometry
  ////////////////////////////////////////

  localparam int DATA_WIDTH     = 64;
  localparam int STRB_WIDTH     = DATA_WIDTH / 8;
  // Address bit LINE_ADDR_BITS picks the bank
  localparam int LINE_ADDR_BITS = $clog2(STRB_WIDTH);

  ////////////////////////////////////////
  // Memory and broadcast region
  ////////////////////////////////////////

  localparam int DMEM_SIZE       = 32768;
  localparam int DMEM_ADDR_WIDTH = $clog2(DMEM_SIZE);
  localparam int BANK_ADDR_WIDTH = DMEM_ADDR_WIDTH - LINE_ADDR_BITS - 1;

  localparam int BC_REGION_SIZE = 4096;
  localparam int BC_START_ADDR  = DMEM_SIZE - BC_REGION_SIZE;
  // Messages carry a 32-bit word address and a 4-bit strobe
  localparam int MSG_ADDR_WIDTH = $clog2(BC_REGION_SIZE) - 2;
  localparam int MSG_WIDTH      = 32 + 4 + MSG_ADDR_WIDTH;

  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [STRB_WIDTH-1:0]      strb_t;
  typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;
  typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;
  // Word address on top, then strobe, then data in the low 32 bits
  typedef logic [MSG_WIDTH-1:0]       msg_t;

endpackage

`default_nettype wire

//--- source/mem_req_pkg.sv
`default_nettype none

package mem_req_pkg;

  import mem_map_pkg::*;

  // One strobed line write, used by the DMA write queue and by broadcasts
  typedef struct packed {
    dmem_addr_t addr;
    strb_t      strb;
    data_t      data;
  } line_wr_t;

  // Core side request, wen low means a read
  typedef struct packed {
    logic       en;
    logic       wen;
    strb_t      strb;
    dmem_addr_t addr;
    data_t      wr_data;
  } core_req_t;

  // Port A command of one bank after arbitration
  typedef struct packed {
    logic       en;
    logic       rd;
    strb_t      wen;
    bank_addr_t addr;
    data_t      wr_data;
  } bank_port_t;

endpackage

`default_nettype wire

//--- source/mem_sys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys import mem_map_pkg::*, mem_req_pkg::*; #(
  parameter int CMD_FIFO_DEPTH_BITS  = 2,
  parameter int RESP_FIFO_DEPTH_BITS = 3
) (
  input  wire             clk,
  input  wire             rst,

  input  wire core_req_t  core_req,
  output data_t           core_rd_data,
  output logic            core_rd_valid,

  input  wire             dma_wr_en,
  input  wire line_wr_t   dma_wr,
  output logic            dma_wr_ready,

  input  wire             dma_rd_en,
  input  wire dmem_addr_t dma_rd_addr,
  output logic            dma_rd_ready,

  output logic            dma_rd_resp_valid,
  output data_t           dma_rd_resp_data,
  input  wire             dma_rd_resp_ready,

  input  wire             bc_msg_valid,
  input  wire msg_t       bc_msg
);

  logic       bc_wr_valid;
  line_wr_t   bc_wr;
  bank_port_t port_a_b0;
  bank_port_t port_a_b1;
  logic       rd_grant;
  logic       rd_grant_bank;
  logic       resp_room;
  data_t      rd_data_b0;
  data_t      rd_data_b1;

  ////////////////////////////////////////
  // Broadcast and DMA into port A
  ////////////////////////////////////////

  bc_msg_unpack bc_unpack (
    .clk        (clk),
    .rst        (rst),
    .msg_valid  (bc_msg_valid),
    .msg        (bc_msg),
    .bc_wr_valid(bc_wr_valid),
    .bc_wr      (bc_wr)
  );

  bank_port_arbiter #(
    .CMD_FIFO_DEPTH_BITS(CMD_FIFO_DEPTH_BITS)
  ) port_arb (
    .clk          (clk),
    .rst          (rst),
    .dma_wr_en    (dma_wr_en),
    .dma_wr       (dma_wr),
    .dma_wr_ready (dma_wr_ready),
    .dma_rd_en    (dma_rd_en),
    .dma_rd_addr  (dma_rd_addr),
    .dma_rd_ready (dma_rd_ready),
    .bc_wr_valid  (bc_wr_valid),
    .bc_wr        (bc_wr),
    .resp_room    (resp_room),
    .port_a_b0    (port_a_b0),
    .port_a_b1    (port_a_b1),
    .rd_grant     (rd_grant),
    .rd_grant_bank(rd_grant_bank)
  );

  ////////////////////////////////////////
  // Banks and read return
  ////////////////////////////////////////

  fast_dmem dmem (
    .clk          (clk),
    .rst          (rst),
    .port_a_b0    (port_a_b0),
    .port_a_b1    (port_a_b1),
    .core         (core_req),
    .rd_data_b0   (rd_data_b0),
    .rd_data_b1   (rd_data_b1),
    .core_rd_data (core_rd_data),
    .core_rd_valid(core_rd_valid)
  );

  dma_rd_resp #(
    .RESP_FIFO_DEPTH_BITS(RESP_FIFO_DEPTH_BITS)
  ) rd_resp (
    .clk              (clk),
    .rst              (rst),
    .rd_grant         (rd_grant),
    .rd_grant_bank    (rd_grant_bank),
    .rd_data_b0       (rd_data_b0),
    .rd_data_b1       (rd_data_b1),
    .resp_room        (resp_room),
    .dma_rd_resp_valid(dma_rd_resp_valid),
    .dma_rd_resp_data (dma_rd_resp_data),
    .dma_rd_resp_ready(dma_rd_resp_ready)
  );

endmodule

`default_nettype wire

//--- source/simple_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module simple_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_BITS = 2
) (
  input  wire              clk,
  input  wire              rst,

  input  wire              din_valid,
  input  wire [WIDTH-1:0]  din,
  output logic             din_ready,

  output logic             dout_valid,
  output logic [WIDTH-1:0] dout,
  input  wire              dout_ready
);

  localparam int DEPTH = 2 ** DEPTH_BITS;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   count;
  logic                  push;
  logic                  pop;

  // Count reaches DEPTH exactly when the top bit is set
  assign din_ready  = !count[DEPTH_BITS];
  assign dout_valid = |count;
  assign dout       = mem[rd_ptr];

  assign push = din_valid && din_ready;
  assign pop  = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verification/mem_sys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys_tb import mem_map_pkg::*, mem_req_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int LINES      = DMEM_SIZE / STRB_WIDTH;
  localparam int CORE_HI    = 16384;
  localparam int DMA_LO     = 16384;
  localparam int DMA_MID    = 22528;
  localparam int DMA_HI     = BC_START_ADDR;
  localparam int N_CORE     = 300;
  localparam int N_DMA      = 200;
  localparam int N_BC       = 200;
  localparam int N_BP       = 300;
  localparam int N_MIX      = 400;
  localparam int TOTAL_OPS  = 2 * LINES + 2 * N_CORE + 2 * N_DMA + N_BC
                              + BC_REGION_SIZE / STRB_WIDTH + N_BP + N_MIX;

  logic       clk;
  logic       rst;
  core_req_t  core_req;
  data_t      core_rd_data;
  logic       core_rd_valid;
  logic       dma_wr_en;
  line_wr_t   dma_wr;
  logic       dma_wr_ready;
  logic       dma_rd_en;
  dmem_addr_t dma_rd_addr;
  logic       dma_rd_ready;
  logic       dma_rd_resp_valid;
  data_t      dma_rd_resp_data;
  logic       dma_rd_resp_ready;
  logic       bc_msg_valid;
  msg_t       bc_msg;

  // Byte image of the memory, updated when each write is issued
  logic [7:0] model [DMEM_SIZE];
  data_t      exp_resp [$];
  data_t      core_exp;
  logic       core_exp_valid;
  logic       bp_mode;
  int         low_hold;
  logic       saw_rd_full;

  mem_sys #(
    .CMD_FIFO_DEPTH_BITS (2),
    .RESP_FIFO_DEPTH_BITS(3)
  ) DUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(20 * TOTAL_OPS * CLK_PERIOD);
    $display("Timeout after %0d clock cycles without finishing the tests", 20 * TOTAL_OPS);
    stop_on_error();
  end

  ////////////////////////////////////////
  // Model and checks
  ////////////////////////////////////////

  // Every address bit feeds the fill value
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return a[7:0] ^ {1'b0, a[14:8]} ^ 8'ha5;
  endfunction

  function automatic data_t model_line(input int unsigned a);
    data_t d;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      d[i*8 +: 8] = model[(a & ~32'h7) + i];
    end
    return d;
  endfunction

  function automatic void model_write(input int unsigned a, input strb_t s, input data_t d);
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (s[i]) begin
        model[(a & ~32'h7) + i] = d[i*8 +: 8];
      end
    end
  endfunction

  function automatic dmem_addr_t rand_line(input int lo, input int hi);
    return dmem_addr_t'(lo + ($urandom % ((hi - lo) / 8)) * 8);
  endfunction

  task automatic stop_on_error();
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("[FAIL] %s expected %h got %h", name, exp, got);
      stop_on_error();
    end
  endtask

  ////////////////////////////////////////
  // Per-cycle driving
  ////////////////////////////////////////

  // Checks what the last edge produced, then returns all inputs to idle
  task automatic tick();
    data_t exp_data;
    @(posedge clk);
    #1;
    check_val("core_rd_valid", 64'(core_exp_valid), 64'(core_rd_valid));
    if (core_exp_valid) begin
      check_val("core_rd_data", core_exp, core_rd_data);
    end
    core_exp_valid = 1'b0;
    core_req       = '0;
    dma_wr_en      = 1'b0;
    dma_rd_en      = 1'b0;
    bc_msg_valid   = 1'b0;
    // Random ready with occasional long stalls
    if (!bp_mode) begin
      dma_rd_resp_ready = 1'b1;
    end else if (low_hold > 0) begin
      dma_rd_resp_ready = 1'b0;
      low_hold--;
    end else if ($urandom % 16 == 0) begin
      dma_rd_resp_ready = 1'b0;
      low_hold = 20 + $urandom % 30;
    end else begin
      dma_rd_resp_ready = 1'($urandom);
    end
    if (dma_rd_resp_valid && dma_rd_resp_ready) begin
      assert (exp_resp.size() > 0) else begin
        $display("A read response arrived with no DMA read outstanding");
        stop_on_error();
      end
      exp_data = exp_resp.pop_front();
      check_val("dma_rd_resp_data", exp_data, dma_rd_resp_data);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic drive_core(input logic wen, input dmem_addr_t a, input strb_t s,
                            input data_t d);
    core_req = '{en: 1'b1, wen: wen, strb: s, addr: a, wr_data: d};
    if (wen) begin
      model_write(a, s, d);
    end else begin
      core_exp_valid = 1'b1;
      core_exp       = model_line(a);
    end
  endtask

  task automatic offer_wr(input line_wr_t w, output logic taken);
    dma_wr_en = 1'b1;
    dma_wr    = w;
    taken     = dma_wr_ready;
    if (taken) begin
      model_write(w.addr, w.strb, w.data);
    end
  endtask

  task automatic offer_rd(input dmem_addr_t a, output logic taken);
    dma_rd_en   = 1'b1;
    dma_rd_addr = a;
    taken       = dma_rd_ready;
    if (taken) begin
      exp_resp.push_back(model_line(a));
    end else begin
      saw_rd_full = 1'b1;
    end
  endtask

  // Word address wa lands at BC_START_ADDR + 4 * wa
  task automatic drive_bc(input logic [9:0] wa, input logic [3:0] s, input logic [31:0] d);
    int unsigned base;
    base         = BC_START_ADDR + 4 * wa;
    bc_msg_valid = 1'b1;
    bc_msg       = {wa, s, d};
    for (int i = 0; i < 4; i++) begin
      if (s[i]) begin
        model[base + i] = d[i*8 +: 8];
      end
    end
  endtask

  task automatic write_dma(input line_wr_t w);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      offer_wr(w, taken);
      tick();
    end
  endtask

  task automatic read_dma(input dmem_addr_t a);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      offer_rd(a, taken);
      tick();
    end
  endtask

  task automatic drain_resp();
    bp_mode  = 1'b0;
    low_hold = 0;
    while (exp_resp.size() > 0) begin
      tick();
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    dmem_addr_t addr_q [$];
    dmem_addr_t a;
    dmem_addr_t pend_rd;
    line_wr_t   pend_wr;
    logic       wr_pend;
    logic       rd_pend;
    logic       taken;
    void'($urandom(57));
    clk = 1'b0;
    rst = 1'b1;
    core_req = '0;
    dma_wr_en = 1'b0;
    dma_wr = '0;
    dma_rd_en = 1'b0;
    dma_rd_addr = '0;
    dma_rd_resp_ready = 1'b0;
    bc_msg_valid = 1'b0;
    bc_msg = '0;
    core_exp = '0;
    core_exp_valid = 1'b0;
    bp_mode = 1'b0;
    low_hold = 0;
    saw_rd_full = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    check_val("dma_rd_resp_valid", 0, 64'(dma_rd_resp_valid));
    check_val("core_rd_valid", 0, 64'(core_rd_valid));
    check_val("dma_wr_ready", 1, 64'(dma_wr_ready));
    check_val("dma_rd_ready", 1, 64'(dma_rd_ready));

    // Known contents everywhere before any read
    for (int i = 0; i < DMEM_SIZE; i += 8) begin
      for (int j = 0; j < 8; j++) begin
        core_exp[j*8 +: 8] = fill_byte(i + j);
      end
      drive_core(1'b1, dmem_addr_t'(i), '1, core_exp);
      tick();
    end

    // Core writes with random strobes, then reads
    for (int i = 0; i < N_CORE; i++) begin
      a = rand_line(0, CORE_HI);
      addr_q.push_back(a);
      drive_core(1'b1, a, strb_t'($urandom), {$urandom, $urandom});
      tick();
    end
    for (int i = 0; i < N_CORE; i++) begin
      drive_core(1'b0, addr_q[$urandom % addr_q.size()], '0, '0);
      tick();
    end

    // DMA writes, then reads of the same lines
    addr_q.delete();
    for (int i = 0; i < N_DMA; i++) begin
      a = rand_line(DMA_LO, DMA_HI);
      addr_q.push_back(a);
      write_dma('{addr: a, strb: strb_t'($urandom), data: {$urandom, $urandom}});
    end
    idle(16);
    foreach (addr_q[i]) begin
      read_dma(addr_q[i]);
    end
    drain_resp();

    // Broadcasts, then the whole region read back
    for (int i = 0; i < N_BC; i++) begin
      drive_bc(10'($urandom), 4'($urandom), $urandom);
      tick();
    end
    idle(8);
    for (int i = BC_START_ADDR; i < DMEM_SIZE; i += 8) begin
      read_dma(dmem_addr_t'(i));
    end
    drain_resp();

    // Reads under response back-pressure, starting with a long stall
    saw_rd_full = 1'b0;
    bp_mode     = 1'b1;
    low_hold    = 60;
    for (int i = 0; i < N_BP; i++) begin
      read_dma(rand_line(DMA_LO, DMA_HI));
    end
    assert (saw_rd_full) else begin
      $display("dma_rd_ready never fell while responses were held back");
      stop_on_error();
    end
    drain_resp();

    // All sources at once, each in its own region
    wr_pend = 1'b0;
    rd_pend = 1'b0;
    bp_mode = 1'b1;
    for (int c = 0; c < N_MIX; c++) begin
      if (!wr_pend && $urandom % 2 == 0) begin
        pend_wr = '{addr: rand_line(DMA_LO, DMA_MID), strb: strb_t'($urandom),
                    data: {$urandom, $urandom}};
        wr_pend = 1'b1;
      end
      if (wr_pend) begin
        offer_wr(pend_wr, taken);
        wr_pend = !taken;
      end
      if (!rd_pend && $urandom % 2 == 0) begin
        pend_rd = rand_line(DMA_MID, DMA_HI);
        rd_pend = 1'b1;
      end
      if (rd_pend) begin
        offer_rd(pend_rd, taken);
        rd_pend = !taken;
      end
      case ($urandom % 3)
        0:       drive_core(1'b1, rand_line(0, CORE_HI), strb_t'($urandom), {$urandom, $urandom});
        1:       drive_core(1'b0, rand_line(0, CORE_HI), '0, '0);
        default: ;
      endcase
      if ($urandom % 2 == 0) begin
        drive_bc(10'($urandom), 4'($urandom), $urandom);
      end
      tick();
    end
    idle(16);
    drain_resp();

    // Final sweep, DMA above the core region and the core below it
    for (int i = DMA_LO; i < DMEM_SIZE; i += 8) begin
      read_dma(dmem_addr_t'(i));
    end
    drain_resp();
    for (int i = 0; i < CORE_HI; i += 8) begin
      drive_core(1'b0, dmem_addr_t'(i), '0, '0);
      tick();
    end
    idle(8);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
